// File: dv/mlpCoreChecker.sv
`timescale 1ns/100ps

module mlpCoreChecker (
	input logic clk,
	input logic reset,
	input nnTypesPkg::inVec_t inData,
	input logic inAck,
	input logic outReq,
	input logic outAck,
	input nnTypesPkg::result_t outResult,
	input logic [127:0] testName,
	input logic tableValid,
	input nnTypesPkg::result_t tableResult,
	input logic endOfTest,
	output int errorCount,
	output int checkCount
);

	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	logic [127:0] nameQ[$];
	inVec_t dataQ[$];
	logic tabValidQ[$];
	result_t tabResultQ[$];
	logic prevInAck;
	logic prevOutReq;
	logic prevOutAck;
	logic prevEnd;
	logic [127:0] curName;
	result_t heldResult;
	result_t expected;
	result_t tabExp;

	// Relu, shift down, clamp.
	function automatic act_t activate(input int sum);
		int shifted;
		if (sum < 0)
			return '0;
		shifted = sum >>> actShift;
		return (shifted > actMax) ? act_t'(actMax) : act_t'(shifted);
	endfunction

	function automatic result_t modelResult(input inVec_t v);
		hidVec_t h;
		result_t r;
		int sum;
		int w;
		for (int k = 0; k < numHid; k++)
		begin
			sum = $signed(hidBias[k]);
			for (int i = 0; i < numIn; i++)
			begin
				w = $signed(hidWeights[k][i]);
				sum = sum + int'(v[i]) * w;
			end
			h[k] = activate(sum);
		end
		for (int k = 0; k < numOut; k++)
		begin
			sum = $signed(outBias[k]);
			for (int i = 0; i < numHid; i++)
			begin
				w = $signed(outWeights[k][i]);
				sum = sum + int'(h[i]) * w;
			end
			r.scores[k] = activate(sum);
		end
		r.classIdx = '0; // First of equal scores stays.
		for (int k = 1; k < numOut; k++)
			if (r.scores[k] > r.scores[r.classIdx])
				r.classIdx = classIdx_t'(k);
		return r;
	endfunction

	task automatic compareField(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		checkCount++;
		if (exp !== act)
		begin
			errorCount++;
			$display("CHECK FAILED %0s %0s expected %h actual %h", curName, what, exp, act);
		end
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			prevInAck = 1'b0;
			prevOutReq = 1'b0;
			prevOutAck = 1'b0;
			prevEnd = 1'b0;
		end
		else
		begin
			if (inAck && !prevInAck)
			begin
				if (dataQ.size() != 0 || outReq || prevOutAck)
				begin
					errorCount++;
					$display("Input was accepted before the previous result was handed off");
				end
				nameQ.push_back(testName);
				dataQ.push_back(inData);
				tabValidQ.push_back(tableValid);
				tabResultQ.push_back(tableResult);
			end
			if (outReq && !prevOutReq)
			begin
				if (dataQ.size() == 0)
				begin
					errorCount++;
					$display("A result was offered with no accepted input outstanding");
				end
				else
				begin
					curName = nameQ.pop_front();
					expected = modelResult(dataQ.pop_front());
					compareField("scores", expected.scores, outResult.scores);
					compareField("classIdx", expected.classIdx, outResult.classIdx);
					tabExp = tabResultQ.pop_front();
					if (tabValidQ.pop_front())
						compareField("table", tabExp, outResult);
				end
				heldResult = outResult;
			end
			else if (outReq && outResult !== heldResult)
			begin
				errorCount++;
				$display("outResult changed while outReq was still high");
			end
			if (endOfTest && !prevEnd && dataQ.size() != 0)
			begin
				errorCount++;
				$display("%0d accepted inputs never produced a result", dataQ.size());
			end
			prevInAck = inAck;
			prevOutReq = outReq;
			prevOutAck = outAck;
			prevEnd = endOfTest;
		end
	end

endmodule

// File: dv/mlpCoreTb.sv
`timescale 1ns/100ps

module mlpCoreTb;

	import nnTypesPkg::*;

	localparam int numTests = 14;
	localparam int longDelay = 40;

	typedef struct packed {
		logic [127:0] name;
		inVec_t data;
		logic [7:0] ackDelay;
		logic hasExpect;
		result_t expResult;
	} stim_t;

	logic clk = 1'b0;
	logic reset;
	logic inReq;
	inVec_t inData;
	logic inAck;
	logic outReq;
	logic outAck;
	result_t outResult;
	logic [127:0] testName;
	logic tableValid;
	result_t tableResult;
	logic endOfTest;
	int errorCount;
	int checkCount;
	stim_t stimTab[numTests];
	int cycleCount = 0;
	int cycleLimit = 0;
	int maxDelay;
	int unsigned seedDummy;

	always #4 clk = ~clk;

	mlpCore dut0 (.clk(clk), .reset(reset), .inReq(inReq), .inData(inData), .inAck(inAck),
		.outReq(outReq), .outAck(outAck), .outResult(outResult));

	mlpCoreChecker checker0 (.clk(clk), .reset(reset), .inData(inData), .inAck(inAck),
		.outReq(outReq), .outAck(outAck), .outResult(outResult), .testName(testName),
		.tableValid(tableValid), .tableResult(tableResult), .endOfTest(endOfTest),
		.errorCount(errorCount), .checkCount(checkCount));

	task automatic setEntry(input int idx, input logic [127:0] name, input inVec_t data,
		input int delay, input logic hasExp, input result_t exp);
		stimTab[idx].name = name;
		stimTab[idx].data = data;
		stimTab[idx].ackDelay = 8'(delay);
		stimTab[idx].hasExpect = hasExp;
		stimTab[idx].expResult = exp;
	endtask

	task automatic fillTable();
		inVec_t v;
		result_t allHigh;
		v = '0;
		setEntry(0, "zeros", v, 2, 1'b1, '0); // Three-way tie at zero.
		allHigh.scores = {8'd118, 8'd234, 8'd196};
		allHigh.classIdx = 2'd1;
		setEntry(1, "allHigh", '1, 5, 1'b1, allHigh);
		v[7] = 8'hff;
		setEntry(2, "oneHot", v, 1, 1'b0, '0);
		v = '0;
		for (int i = 0; i < 5; i++)
			v[i] = 8'hff;
		setEntry(3, "saturate", v, longDelay, 1'b0, '0); // Hidden neuron 2 clamps at 255.
		for (int j = 0; j < 10; j++)
		begin
			for (int i = 0; i < numIn; i++)
				v[i] = act_t'($urandom);
			setEntry(4 + j, {"rand", 8'h30 + 8'(j)}, v, $urandom % 16, 1'b0, '0);
		end
	endtask

	// Upstream side of the input handshake.
	task automatic sendVector(input stim_t s);
		inData = s.data;
		testName = s.name;
		tableValid = s.hasExpect;
		tableResult = s.expResult;
		inReq = 1'b1;
		@(negedge clk);
		while (!inAck)
			@(negedge clk);
		inReq = 1'b0;
		while (inAck)
			@(negedge clk);
	endtask

	task automatic takeResult(input int delay);
		while (!outReq)
			@(negedge clk);
		repeat (delay)
			@(negedge clk);
		outAck = 1'b1;
		while (outReq)
			@(negedge clk);
		repeat (2)
			@(negedge clk); // A late outAck release keeps the next input blocked.
		outAck = 1'b0;
	endtask

	task automatic closeRun();
		int totalErrors;
		totalErrors = errorCount + dut0.props0.failCount;
		$display("Errors: %0d  Checks: %0d", totalErrors, checkCount);
		if (totalErrors == 0 && checkCount > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, a handshake never completed", cycleCount);
			$display("Errors: %0d  Checks: %0d", errorCount + dut0.props0.failCount,
				checkCount);
			$display("Some tests failed");
			$finish;
		end
	end

	initial
	begin
		seedDummy = $urandom(32'h426a);
		reset = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		testName = '0;
		tableValid = 1'b0;
		tableResult = '0;
		endOfTest = 1'b0;
		fillTable();
		maxDelay = 0;
		for (int t = 0; t < numTests; t++)
			if (stimTab[t].ackDelay > maxDelay)
				maxDelay = stimTab[t].ackDelay;
		cycleLimit = numTests * (8 + maxDelay + 6) * 2;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		// Next vector waits on inReq while the previous result is still held.
		fork
			for (int t = 0; t < numTests; t++)
				sendVector(stimTab[t]);
			for (int t = 0; t < numTests; t++)
				takeResult(stimTab[t].ackDelay);
		join
		endOfTest = 1'b1;
		repeat (2) @(negedge clk);
		closeRun();
	end

endmodule

// File: dv/mlpCore_props.sv
`timescale 1ns/100ps

module mlpCoreProps (
	input logic clk,
	input logic reset,
	input logic inReq,
	input logic inAck,
	input logic outReq,
	input logic outAck,
	input nnTypesPkg::result_t outResult
);

	import nnTypesPkg::*;

	localparam int reqDelay = pipeLatency + 2; // Capture edge and score register.

	int failCount = 0;

	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) |-> $past(inReq))
		else
		begin
			failCount++;
			$error("inAck rose while inReq was low");
		end

	holdUntilAck: assert property (@(posedge clk) disable iff (reset)
		(outReq && !outAck) |=> (outReq && $stable(outResult)))
		else
		begin
			failCount++;
			$error("outReq or outResult moved before outAck");
		end

	reqLatency: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) |-> (!outReq)[*reqDelay] ##1 outReq)
		else
		begin
			failCount++;
			$error("outReq did not rise 8 edges after capture");
		end

	resetIdle: assert property (@(posedge clk)
		reset |=> (!inAck && !outReq))
		else
		begin
			failCount++;
			$error("Handshake outputs not low after reset");
		end

endmodule

bind mlpCore mlpCoreProps props0 (
	.clk(clk),
	.reset(reset),
	.inReq(inReq),
	.inAck(inAck),
	.outReq(outReq),
	.outAck(outAck),
	.outResult(outResult)
);

// File: mlpCore.f
rtl/nnTypesPkg.sv
rtl/nnWeightsPkg.sv
rtl/neuronNode.sv
rtl/denseLayer.sv
rtl/inferenceCtrl.sv
rtl/mlpCore.sv
dv/mlpCoreChecker.sv
dv/mlpCore_props.sv
dv/mlpCoreTb.sv

// File: rtl/denseLayer.sv
`timescale 1ns/100ps

module denseLayer #(
	parameter int nIn = 15,
	parameter int nOut = 6,
	parameter nnTypesPkg::weight_t [0:nOut-1][0:nIn-1] weightTab = '0,
	parameter nnTypesPkg::weight_t [0:nOut-1] biasTab = '0
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::act_t [nIn-1:0] acts,
	output nnTypesPkg::act_t [nOut-1:0] ys
);

	// All nodes see the same vector, so the layer keeps the node latency.
	genvar k;
	generate
		for (k = 0; k < nOut; k++)
		begin : nodeGen
			localparam nnTypesPkg::weight_t [0:nIn-1] rowWeights = weightTab[k];
			localparam nnTypesPkg::weight_t rowBias = biasTab[k];

			neuronNode #(
				.width(nIn),
				.weights(rowWeights),
				.bias(rowBias)
			) node0 (
				.clk(clk),
				.reset(reset),
				.acts(acts),
				.y(ys[k])
			);
		end
	endgenerate

endmodule

// File: rtl/inferenceCtrl.sv
`timescale 1ns/100ps

module inferenceCtrl (
	input logic clk,
	input logic reset,
	input logic inReq,
	input nnTypesPkg::inVec_t inData,
	output logic inAck,
	output nnTypesPkg::inVec_t capVec,
	input nnTypesPkg::outVec_t scoreVec,
	output logic outReq,
	input logic outAck,
	output nnTypesPkg::result_t outResult
);

	import nnTypesPkg::*;

	// One extra step covers the score register in front of the argmax.
	localparam int countLoad = pipeLatency + 1;
	localparam int cntW = $clog2(countLoad + 1);

	ctrlState_t state;
	logic [cntW-1:0] count;
	logic accept;
	outVec_t scoreReg;
	classIdx_t bestIdx;

	function automatic classIdx_t argMax(input outVec_t scores);
		classIdx_t best;
		best = '0;
		for (int i = 1; i < numOut; i++)
		begin
			if (scores[i] > scores[best]) // Strict compare keeps the lower index.
				best = classIdx_t'(i);
		end
		return best;
	endfunction

	assign accept = (state == stIdle) && inReq && !inAck;
	assign bestIdx = argMax(scoreReg);

	// Held from capture until the next accepted vector.
	always_ff @(posedge clk)
	begin
		if (accept)
			capVec <= inData;
	end

	always_ff @(posedge clk)
	begin
		scoreReg <= scoreVec;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
			count <= '0;
			inAck <= 1'b0;
			outReq <= 1'b0;
			outResult <= '0;
		end
		else
		begin
			if (accept)
				inAck <= 1'b1;
			else if (!inReq)
				inAck <= 1'b0; // Upstream has let go.

			case (state)
				stIdle:
				begin
					if (accept)
					begin
						count <= cntW'(countLoad);
						state <= stRun;
					end
				end
				stRun:
				begin
					if (count == '0)
					begin
						outResult.scores <= scoreReg;
						outResult.classIdx <= bestIdx;
						outReq <= 1'b1;
						state <= stPresent;
					end
					else
					begin
						count <= count - 1'b1;
					end
				end
				stPresent:
				begin
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= stRelease;
					end
				end
				stRelease:
				begin
					// Both handshakes must be back at rest.
					if (!outAck && !inAck)
						state <= stIdle;
				end
				default:
				begin
					state <= stIdle;
				end
			endcase
		end
	end

endmodule

// File: rtl/mlpCore.sv
`timescale 1ns/100ps

module mlpCore (
	input logic clk,
	input logic reset,
	input logic inReq,
	input nnTypesPkg::inVec_t inData,
	output logic inAck,
	output logic outReq,
	input logic outAck,
	output nnTypesPkg::result_t outResult
);

	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	inVec_t capVec;
	hidVec_t hidVec;
	outVec_t scoreVec;

	inferenceCtrl ctrl0 (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.capVec(capVec),
		.scoreVec(scoreVec),
		.outReq(outReq),
		.outAck(outAck),
		.outResult(outResult)
	);

	// Fifteen inputs to six hidden neurons.
	denseLayer #(
		.nIn(numIn),
		.nOut(numHid),
		.weightTab(hidWeights),
		.biasTab(hidBias)
	) hidLayer0 (
		.clk(clk),
		.reset(reset),
		.acts(capVec),
		.ys(hidVec)
	);

	// Six hidden values to three scores.
	denseLayer #(
		.nIn(numHid),
		.nOut(numOut),
		.weightTab(outWeights),
		.biasTab(outBias)
	) outLayer0 (
		.clk(clk),
		.reset(reset),
		.acts(hidVec),
		.ys(scoreVec)
	);

endmodule

// File: rtl/neuronNode.sv
`timescale 1ns/100ps

module neuronNode #(
	parameter int width = 15,
	parameter nnTypesPkg::weight_t [0:width-1] weights = '0,
	parameter nnTypesPkg::weight_t bias = '0
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::act_t [width-1:0] acts,
	output nnTypesPkg::act_t y
);

	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	act_t [width-1:0] actsReg;
	acc_t sumNext;
	acc_t sumReg;
	acc_t shifted;

	// Stage one. Inputs are held here.
	always_ff @(posedge clk)
	begin
		actsReg <= acts;
	end

	// Activations are unsigned, so a zero bit goes on top before the signed multiply.
	always_comb
	begin
		sumNext = acc_t'(bias);
		for (int i = 0; i < width; i++)
		begin
			sumNext = sumNext + $signed({1'b0, actsReg[i]}) * $signed(weights[i]);
		end
	end

	// Stage two.
	always_ff @(posedge clk)
	begin
		sumReg <= sumNext;
	end

	assign shifted = sumReg >>> actShift;

	// Stage three. Rectify, then clamp to the activation range.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			y <= '0;
		end
		else if (sumReg < 0)
		begin
			y <= '0;
		end
		else if (shifted > actMax)
		begin
			y <= act_t'(actMax); // Saturate.
		end
		else
		begin
			y <= act_t'(shifted);
		end
	end

endmodule

// File: rtl/nnTypesPkg.sv
package nnTypesPkg;

	localparam int actW = 8;
	localparam int wgtW = 8;
	localparam int accW = 20; // Fifteen full-scale products plus bias fit here.

	localparam int numIn = 15;
	localparam int numHid = 6;
	localparam int numOut = 3;

	// Every layer is input reg, sum reg, output reg.
	localparam int numLayers = 2;
	localparam int layerLatency = 3;
	localparam int pipeLatency = numLayers * layerLatency;

	typedef logic [actW-1:0] act_t;
	typedef logic signed [wgtW-1:0] weight_t;
	typedef logic signed [accW-1:0] acc_t;
	typedef logic [1:0] classIdx_t;

	typedef act_t [numIn-1:0] inVec_t;
	typedef act_t [numHid-1:0] hidVec_t;
	typedef act_t [numOut-1:0] outVec_t;

	// Handed off on the output handshake.
	typedef struct packed {
		outVec_t scores;
		classIdx_t classIdx; // Lowest index wins a tie.
	} result_t;

	typedef enum logic [1:0] {
		stIdle,
		stRun,
		stPresent,
		stRelease
	} ctrlState_t;

endpackage

// File: rtl/nnWeightsPkg.sv
package nnWeightsPkg;

	import nnTypesPkg::*;

	// Activation is relu, then a right shift, then a clamp.
	localparam int actShift = 6;
	localparam int actMax = 255;

	// Row k feeds hidden neuron k, column i pairs with input i.
	localparam weight_t [0:numHid-1][0:numIn-1] hidWeights = '{
		'{12, -31, 45, 7, -19, 26, -40, 33, 18, -6, 52, -27, 9, 41, -14},
		'{-22, 17, -9, 38, 29, -45, 11, -3, 36, 24, -18, 50, -33, 6, 27},
		'{48, 55, 61, 39, 44, 57, 63, 42, 50, 58, 47, 53, 60, 45, 49},
		'{-8, -26, 14, -37, 21, 35, -12, 28, -41, 19, 7, -23, 30, -16, 43},
		'{31, 9, -28, 16, -5, -34, 40, 22, -11, 37, -29, 13, 25, -38, 4},
		'{-15, 42, 19, -24, 33, 10, -36, 47, 2, -20, 34, -9, 15, 26, -31}
	};

	// Kept below one shifted step so a zero input gives zero hidden values.
	localparam weight_t [0:numHid-1] hidBias = '{
		-5,
		12,
		20,
		-17,
		8,
		-30
	};

	localparam weight_t [0:numOut-1][0:numHid-1] outWeights = '{
		'{21, -14, 33, -27, 18, 9},
		'{-12, 30, 16, 25, -20, 28},
		'{27, 8, -19, 14, 35, -22}
	};

	localparam weight_t [0:numOut-1] outBias = '{
		4,
		-6,
		10
	};

endpackage
